// ==== Bender.yml ====
package:
  name: gnn_accu

sources:
  - rtl/gnn_accu_pkg.sv
  - rtl/wb_host_port.sv
  - rtl/vertex_pe.sv
  - rtl/accu_bank.sv
  - rtl/result_store.sv
  - rtl/gnn_accu_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_gnn_accu.sv

// ==== list.f ====
+incdir+verif
rtl/gnn_accu_pkg.sv
rtl/wb_host_port.sv
rtl/vertex_pe.sv
rtl/accu_bank.sv
rtl/result_store.sv
rtl/gnn_accu_top.sv
verif/tb_gnn_accu.sv

// ==== rtl/accu_bank.sv ====
`timescale 1ns/1ps

module accu_bank (
    input  logic                        clk,
    input  logic                        reset,
    input  gnn_accu_pkg::vertex_data_t  vertex_data,
    input  gnn_accu_pkg::vertex_cntl_t  vertex_cntl,
    input  logic                        req_grant,
    output logic                        bank_busy,
    output gnn_accu_pkg::out_pair_t     out_pair
);

    import gnn_accu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        STREAM_IN,
        OUT_WAIT,
        OUT
    } state_t;

    state_t state;

    logic [MAX_FV_NUM-1:0][FV_SIZE-1:0] buffer;
    logic [FV_CNT_W-1:0]                cnt;
    logic [FV_CNT_W-1:0]                fv_num;
    logic [NODE_ID_W-1:0]               cur_node_id;
    logic [FV_IDX_W-1:0]                idx_lo;
    logic [FV_IDX_W-1:0]                idx_hi;
    logic [FV_SIZE-1:0]                 acc_sum;
    logic                               last_pair;

    assign idx_lo    = cnt[FV_IDX_W-1:0];
    assign idx_hi    = idx_lo + 1'b1;
    // wraps modulo 256
    assign acc_sum   = buffer[idx_lo] + vertex_data.data;
    assign last_pair = (cnt + FV_CNT_W'(2)) >= fv_num;

    assign bank_busy = (state != IDLE);

    always_comb begin
        out_pair         = '0;
        out_pair.node_id = cur_node_id;
        out_pair.data    = {buffer[idx_hi], buffer[idx_lo]};
        case (state)
            OUT_WAIT: begin
                // req stays up through the grant cycle
                out_pair.req = 1'b1;
                if (req_grant) begin
                    out_pair.grant_valid = 1'b1;
                    out_pair.sos         = 1'b1;
                    out_pair.eos         = last_pair;
                end
            end
            OUT: begin
                out_pair.grant_valid = 1'b1;
                out_pair.eos         = last_pair;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            buffer      <= '0;
            cnt         <= '0;
            fv_num      <= '0;
            cur_node_id <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (vertex_cntl.sos) begin
                        buffer[idx_lo] <= acc_sum;
                        cur_node_id    <= vertex_data.node_id;
                        if (vertex_cntl.eos) begin
                            fv_num <= cnt + 1'b1;
                            state  <= OUT_WAIT;
                        end else begin
                            state <= STREAM_IN;
                            if (vertex_cntl.change) begin
                                cnt <= cnt + 1'b1;
                            end
                        end
                    end
                end
                STREAM_IN: begin
                    buffer[idx_lo] <= acc_sum;
                    if (vertex_cntl.eos) begin
                        fv_num <= cnt + 1'b1;
                        cnt    <= '0;
                        state  <= OUT_WAIT;
                    end else if (vertex_cntl.change) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                OUT_WAIT: begin
                    if (req_grant) begin
                        if (last_pair) begin
                            state  <= IDLE;
                            cnt    <= '0;
                            buffer <= '0;
                        end else begin
                            state <= OUT;
                            cnt   <= cnt + FV_CNT_W'(2);
                        end
                    end
                end
                OUT: begin
                    if (last_pair) begin
                        state  <= IDLE;
                        cnt    <= '0;
                        buffer <= '0;
                    end else begin
                        cnt <= cnt + FV_CNT_W'(2);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/gnn_accu_pkg.sv ====
package gnn_accu_pkg;

    // feature vector geometry
    localparam int MAX_FV_NUM     = 8;
    localparam int FV_SIZE        = 8;
    localparam int MAX_NODE_ID    = 16;
    localparam int PAIRS_PER_NODE = MAX_FV_NUM / 2;
    localparam int STORE_DEPTH    = MAX_NODE_ID * PAIRS_PER_NODE;

    // derived widths
    localparam int NODE_ID_W   = $clog2(MAX_NODE_ID);
    localparam int FV_IDX_W    = $clog2(MAX_FV_NUM);
    localparam int FV_CNT_W    = FV_IDX_W + 1;
    localparam int PAIR_IDX_W  = $clog2(PAIRS_PER_NODE);
    localparam int STORE_IDX_W = $clog2(STORE_DEPTH);
    localparam int PAIR_W      = 2 * FV_SIZE;

    // wishbone bus widths
    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 32;

    // host word addresses
    localparam logic [WB_ADR_W-1:0] ADR_STREAM      = 8'h00;
    localparam logic [WB_ADR_W-1:0] ADR_STATUS      = 8'h01;
    localparam logic [WB_ADR_W-1:0] ADR_RESULT_BASE = 8'h40;

    // host to pe beat, declared msb first so feature lands in dat_w[7:0]
    // change flags the last beat of an element; eos is the last beat of the node
    typedef struct packed {
        logic                 eos;
        logic                 change;
        logic                 sos;
        logic [NODE_ID_W-1:0] node_id;
        logic [FV_SIZE-1:0]   weight;
        logic [FV_SIZE-1:0]   feature;
    } edge_beat_t;

    typedef struct packed {
        logic [FV_SIZE-1:0]   data;
        logic [NODE_ID_W-1:0] node_id;
    } vertex_data_t;

    typedef struct packed {
        logic sos;
        logic change;
        logic eos;
    } vertex_cntl_t;

    // even element sits in data[7:0]
    typedef struct packed {
        logic                 req;
        logic                 grant_valid;
        logic                 sos;
        logic                 eos;
        logic [NODE_ID_W-1:0] node_id;
        logic [PAIR_W-1:0]    data;
    } out_pair_t;

endpackage

// ==== rtl/gnn_accu_top.sv ====
`timescale 1ns/1ps

module gnn_accu_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [gnn_accu_pkg::WB_ADR_W-1:0] adr,
    input  logic [gnn_accu_pkg::WB_DAT_W-1:0] dat_w,
    output logic [gnn_accu_pkg::WB_DAT_W-1:0] dat_r,
    output logic                              ack
);

    import gnn_accu_pkg::*;

    edge_beat_t   beat;
    vertex_data_t vertex_data;
    vertex_cntl_t vertex_cntl;
    out_pair_t    out_pair;

    logic                   beat_valid;
    logic                   pe_ready;
    logic                   pe_holding;
    logic                   bank_busy;
    logic                   engine_busy;
    logic                   req_grant;
    logic [STORE_IDX_W-1:0] rd_index;
    logic [PAIR_W-1:0]      rd_data;

    assign engine_busy = pe_holding || bank_busy;

    wb_host_port u_host (
        .clk         (clk),
        .reset       (reset),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .pe_ready    (pe_ready),
        .engine_busy (engine_busy),
        .beat_valid  (beat_valid),
        .beat        (beat),
        .rd_index    (rd_index),
        .rd_data     (rd_data)
    );

    vertex_pe u_pe (
        .clk         (clk),
        .reset       (reset),
        .beat_valid  (beat_valid),
        .beat        (beat),
        .vertex_data (vertex_data),
        .vertex_cntl (vertex_cntl),
        .bank_busy   (bank_busy),
        .pe_ready    (pe_ready),
        .pe_holding  (pe_holding)
    );

    accu_bank u_bank (
        .clk         (clk),
        .reset       (reset),
        .vertex_data (vertex_data),
        .vertex_cntl (vertex_cntl),
        .req_grant   (req_grant),
        .bank_busy   (bank_busy),
        .out_pair    (out_pair)
    );

    result_store u_store (
        .clk       (clk),
        .reset     (reset),
        .out_pair  (out_pair),
        .req_grant (req_grant),
        .rd_index  (rd_index),
        .rd_data   (rd_data)
    );

endmodule

// ==== rtl/result_store.sv ====
`timescale 1ns/1ps

module result_store (
    input  logic                                  clk,
    input  logic                                  reset,
    input  gnn_accu_pkg::out_pair_t               out_pair,
    output logic                                  req_grant,
    input  logic [gnn_accu_pkg::STORE_IDX_W-1:0]  rd_index,
    output logic [gnn_accu_pkg::PAIR_W-1:0]       rd_data
);

    import gnn_accu_pkg::*;

    logic [PAIR_W-1:0]      mem [STORE_DEPTH];
    logic [PAIR_IDX_W-1:0]  pair_cnt;
    logic [PAIR_IDX_W-1:0]  pair_idx;
    logic [STORE_IDX_W-1:0] wr_index;
    logic                   writing;

    assign req_grant = out_pair.req && !writing;

    // first pair of a stream always goes to slot 0 of the node
    assign pair_idx = out_pair.sos ? '0 : pair_cnt;
    assign wr_index = {out_pair.node_id, pair_idx};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < STORE_DEPTH; i++) begin
                mem[i] <= '0;
            end
            pair_cnt <= '0;
            writing  <= 1'b0;
        end else if (out_pair.grant_valid) begin
            mem[wr_index] <= out_pair.data;
            if (out_pair.eos) begin
                pair_cnt <= '0;
                writing  <= 1'b0;
            end else begin
                pair_cnt <= pair_idx + 1'b1;
                writing  <= 1'b1;
            end
        end
    end

    // host read port
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_index];
    end

endmodule

// ==== rtl/vertex_pe.sv ====
`timescale 1ns/1ps

module vertex_pe (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        beat_valid,
    input  gnn_accu_pkg::edge_beat_t    beat,
    output gnn_accu_pkg::vertex_data_t  vertex_data,
    output gnn_accu_pkg::vertex_cntl_t  vertex_cntl,
    input  logic                        bank_busy,
    output logic                        pe_ready,
    output logic                        pe_holding
);

    import gnn_accu_pkg::*;

    logic [2*FV_SIZE-1:0] product;
    logic                 valid_q;
    logic                 draining;

    assign product = beat.weight * beat.feature;

    always_ff @(posedge clk) begin
        if (reset) begin
            vertex_data <= '0;
            vertex_cntl <= '0;
            valid_q     <= 1'b0;
        end else begin
            valid_q            <= beat_valid;
            vertex_cntl.sos    <= beat_valid && beat.sos;
            vertex_cntl.change <= beat_valid && beat.change;
            vertex_cntl.eos    <= beat_valid && beat.eos;
            // zero data on idle cycles so the bank can add unconditionally
            vertex_data.data    <= beat_valid ? product[FV_SIZE-1:0] : '0;
            vertex_data.node_id <= beat.node_id;
        end
    end

    // set once an eos has gone out, held until the bank drops busy
    always_ff @(posedge clk) begin
        if (reset) begin
            draining <= 1'b0;
        end else if (vertex_cntl.eos) begin
            draining <= 1'b1;
        end else if (!bank_busy) begin
            draining <= 1'b0;
        end
    end

    assign pe_ready   = !vertex_cntl.eos && !(draining && bank_busy);
    assign pe_holding = valid_q;

endmodule

// ==== rtl/wb_host_port.sv ====
`timescale 1ns/1ps

module wb_host_port (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cyc,
    input  logic                                  stb,
    input  logic                                  we,
    input  logic [gnn_accu_pkg::WB_ADR_W-1:0]     adr,
    input  logic [gnn_accu_pkg::WB_DAT_W-1:0]     dat_w,
    output logic [gnn_accu_pkg::WB_DAT_W-1:0]     dat_r,
    output logic                                  ack,
    input  logic                                  pe_ready,
    input  logic                                  engine_busy,
    output logic                                  beat_valid,
    output gnn_accu_pkg::edge_beat_t              beat,
    output logic [gnn_accu_pkg::STORE_IDX_W-1:0]  rd_index,
    input  logic [gnn_accu_pkg::PAIR_W-1:0]       rd_data
);

    import gnn_accu_pkg::*;

    logic xfer;
    logic is_stream;
    logic is_status;
    logic is_result;
    logic stream_wr;
    logic accept;
    logic rd_result_q;
    logic status_q;

    // a transfer is only seen again once the previous ack has dropped
    assign xfer      = cyc && stb && !ack;
    assign is_stream = (adr == ADR_STREAM);
    assign is_status = (adr == ADR_STATUS);
    assign is_result = (adr[WB_ADR_W-1:STORE_IDX_W] ==
                        ADR_RESULT_BASE[WB_ADR_W-1:STORE_IDX_W]);

    assign stream_wr = xfer && we && is_stream;

    // stream writes wait for the pe while everything else acks right away
    assign accept = xfer && (!stream_wr || pe_ready);

    // store read port is registered and lines up with the ack cycle
    assign rd_index = adr[STORE_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            ack         <= 1'b0;
            beat_valid  <= 1'b0;
            rd_result_q <= 1'b0;
            status_q    <= 1'b0;
        end else begin
            ack         <= accept;
            beat_valid  <= accept && stream_wr;
            rd_result_q <= accept && !we && is_result;
            status_q    <= accept && !we && is_status && engine_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (stream_wr) begin
            beat <= edge_beat_t'(dat_w[$bits(edge_beat_t)-1:0]);
        end
    end

    always_comb begin
        if (rd_result_q) begin
            dat_r = {{(WB_DAT_W-PAIR_W){1'b0}}, rd_data};
        end else begin
            dat_r = {{(WB_DAT_W-1){1'b0}}, status_q};
        end
    end

endmodule

// ==== verif/tb_wb_tasks.svh ====
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// waits out one transfer on the falling edges, then releases the bus
task automatic wait_for_ack(input logic [7:0] addr, output int waited);
    waited = 0;
    @(negedge clk);
    while (!ack && waited < ACK_LIMIT) begin
        waited++;
        @(negedge clk);
    end
    assert (ack) else begin
        errors++;
        $display("no ack from the DUT for address 0x%02h after %0d cycles", addr, waited);
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
endtask

// stall is the number of cycles the ack was held off
task automatic write_word(input logic [7:0] addr, input logic [31:0] data, output int stall);
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = addr;
    dat_w = data;
    wait_for_ack(addr, stall);
endtask

task automatic read_word(input logic [7:0] addr, output logic [31:0] data);
    int waited;
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = addr;
    wait_for_ack(addr, waited);
    data = dat_r;
endtask

task automatic wait_until_idle();
    logic [31:0] status;
    int          polls;
    polls = 0;
    read_word(ADR_STATUS, status);
    while (status[0] && polls < POLL_LIMIT) begin
        polls++;
        read_word(ADR_STATUS, status);
    end
    assert (!status[0]) else begin
        errors++;
        $display("engine still busy after %0d status polls", polls);
    end
endtask

`endif

// ==== verif/tb_gnn_accu.sv ====
`timescale 1ns/1ps

module tb_gnn_accu;

    import gnn_accu_pkg::*;

    localparam int NUM_JOBS   = 7;
    localparam int ACK_LIMIT  = 100;
    localparam int POLL_LIMIT = 100;

    // one node job per row
    typedef struct packed {
        logic [3:0] node_id;
        logic [3:0] fv_num;
        logic [2:0] beats;
        logic       use_lcg;
        logic       chain;
        logic [7:0] feature;
        logic [7:0] weight;
    } job_t;

    logic                clk;
    logic                reset;
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat_w;
    logic [WB_DAT_W-1:0] dat_r;
    logic                ack;

    job_t        jobs [NUM_JOBS];
    logic [31:0] expected_mem [STORE_DEPTH];
    logic [31:0] seed;
    int          errors;
    int          checks;
    int          max_stall;
    int          cycles;
    int          cycle_limit;
    int          total_beats;

    gnn_accu_top dut (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles, the DUT never let the tests finish", cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    `include "tb_wb_tasks.svh"

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] next_random();
        seed = lcg_step(seed);
        return seed[23:16];
    endfunction

    function automatic job_t make_job(input logic [3:0] node_id, input logic [3:0] fv_num,
            input logic [2:0] beats, input logic use_lcg, input logic chain,
            input logic [7:0] feature, input logic [7:0] weight);
        return {node_id, fv_num, beats, use_lcg, chain, feature, weight};
    endfunction

    // stream word, feature in the low byte up to eos at bit 22
    function automatic logic [31:0] beat_word(input logic [3:0] node, input logic [7:0] feature,
            input logic [7:0] weight, input logic sos, input logic change, input logic eos);
        return {9'b0, eos, change, sos, node, weight, feature};
    endfunction

    task automatic check_word(input logic [7:0] addr, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %0t: word at 0x%02h is 0x%08h, expected 0x%08h", $time, addr, got, exp);
        end
    endtask

    task automatic sweep_results();
        logic [31:0] got;
        for (int i = 0; i < STORE_DEPTH; i++) begin
            read_word(ADR_RESULT_BASE + 8'(i), got);
            check_word(ADR_RESULT_BASE + 8'(i), got, expected_mem[i]);
        end
    endtask

    task automatic run_job(input job_t job);
        logic [7:0]  sums [MAX_FV_NUM];
        logic [7:0]  feature;
        logic [7:0]  weight;
        logic [15:0] product;
        logic [31:0] got;
        logic        last;
        int          stall;
        int          idx;
        for (int e = 0; e < MAX_FV_NUM; e++) begin
            sums[e] = 8'h00;
        end
        for (int e = 0; e < int'(job.fv_num); e++) begin
            for (int k = 0; k < int'(job.beats); k++) begin
                if (job.use_lcg) begin
                    feature = next_random();
                    weight  = next_random();
                end else begin
                    feature = job.feature + 8'(e);
                    weight  = job.weight + 8'(k);
                end
                product = feature * weight;
                sums[e] = sums[e] + product[7:0];
                last    = (e == int'(job.fv_num) - 1) && (k == int'(job.beats) - 1);
                write_word(ADR_STREAM, beat_word(job.node_id, feature, weight,
                           e == 0 && k == 0, k == int'(job.beats) - 1 && !last, last), stall);
                if (stall > max_stall) begin
                    max_stall = stall;
                end
            end
        end
        // even element low, a missing odd element reads as zero
        for (int p = 0; p < (int'(job.fv_num) + 1) / 2; p++) begin
            idx = int'(job.node_id) * PAIRS_PER_NODE + p;
            expected_mem[idx] = {16'h0000,
                                 (2 * p + 1 < int'(job.fv_num)) ? sums[2 * p + 1] : 8'h00,
                                 sums[2 * p]};
        end
        if (!job.chain) begin
            wait_until_idle();
            for (int p = 0; p < (int'(job.fv_num) + 1) / 2; p++) begin
                idx = int'(job.node_id) * PAIRS_PER_NODE + p;
                read_word(ADR_RESULT_BASE + 8'(idx), got);
                check_word(ADR_RESULT_BASE + 8'(idx), got, expected_mem[idx]);
            end
        end
    endtask

    initial begin
        logic [31:0] status;
        clk         = 1'b0;
        reset       = 1'b1;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        seed        = 32'd30997;
        errors      = 0;
        checks      = 0;
        max_stall   = 0;
        cycles      = 0;
        total_beats = 0;

        //                  node   n      beats  lcg   chain feature weight
        jobs[0] = make_job(4'd3,  4'd1, 3'd1, 1'b0, 1'b0, 8'h05, 8'h07);
        jobs[1] = make_job(4'd7,  4'd5, 3'd3, 1'b0, 1'b0, 8'h0c, 8'h03);
        // large values so products and sums wrap
        jobs[2] = make_job(4'd9,  4'd8, 3'd2, 1'b0, 1'b0, 8'hf1, 8'hc3);
        // back to back, the next sos waits on the bank
        jobs[3] = make_job(4'd0,  4'd8, 3'd1, 1'b1, 1'b1, 8'h00, 8'h00);
        jobs[4] = make_job(4'd1,  4'd3, 3'd4, 1'b1, 1'b1, 8'h00, 8'h00);
        jobs[5] = make_job(4'd15, 4'd7, 3'd1, 1'b1, 1'b0, 8'h00, 8'h00);
        // node 7 again, only its first word changes
        jobs[6] = make_job(4'd7,  4'd2, 3'd2, 1'b1, 1'b0, 8'h00, 8'h00);

        for (int j = 0; j < NUM_JOBS; j++) begin
            total_beats += int'(jobs[j].fv_num) * int'(jobs[j].beats);
        end
        cycle_limit = 40 * total_beats + 2000;
        for (int i = 0; i < STORE_DEPTH; i++) begin
            expected_mem[i] = 32'h0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        read_word(ADR_STATUS, status);
        check_word(ADR_STATUS, status, 32'h0);
        sweep_results();

        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(jobs[j]);
        end
        sweep_results();

        assert (max_stall > 0) else begin
            errors++;
            $display("no stream write was ever held off by the DUT");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
